/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_simd_noncomp_slice
FILELIST  := compile.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@! grep -q "test failed" $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
rtl/simd_slice_pkg.sv
rtl/operand_unpack.sv
rtl/noncomp_lane.sv
rtl/result_pack.sv
rtl/simd_noncomp_slice.sv
testbench/slice_assert.sv
testbench/tb_simd_noncomp_slice.sv

/* rtl/noncomp_lane.sv */
// One SIMD lane: sign injection and min/max per format, followed by valid/ready pipe stages
`timescale 1ns/1ps
`default_nettype none

module noncomp_lane #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic [simd_slice_pkg::SLICE_WIDTH-1:0] operand_a_i,
  input  logic [simd_slice_pkg::SLICE_WIDTH-1:0] operand_b_i,
  input  simd_slice_pkg::operation_e             op_i,
  input  simd_slice_pkg::roundmode_e             rnd_mode_i,
  input  simd_slice_pkg::fp_format_e             dst_fmt_i,
  input  logic                                   vector_i,
  input  logic                                   mask_i,
  input  logic [simd_slice_pkg::TAG_WIDTH-1:0]   tag_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  output logic [simd_slice_pkg::SLICE_WIDTH-1:0] result_o,
  output simd_slice_pkg::status_t                status_o,
  output logic                                   vector_o,
  output simd_slice_pkg::fp_format_e             dst_fmt_o,
  output logic [simd_slice_pkg::TAG_WIDTH-1:0]   tag_o,
  output logic                                   mask_o,
  output logic                                   out_valid_o,
  input  logic                                   out_ready_i,
  output logic                                   busy_o
);

  import simd_slice_pkg::*;

  localparam int unsigned LANE_W    = lane_width(LaneIdx);
  localparam int unsigned PAYLOAD_W = SLICE_WIDTH + NUM_STATUS + 1 + $bits(fp_format_e)
                                      + TAG_WIDTH + 1;

  logic [SLICE_WIDTH-1:0] fmt_result  [NUM_FORMATS];
  logic                   fmt_invalid [NUM_FORMATS];
  logic [SLICE_WIDTH-1:0] result_d;
  status_t                status_d;

  // --------------------
  // Per-format datapath
  // --------------------
  for (genvar f = 0; f < NUM_FORMATS; f++) begin : gen_fmt
    localparam int unsigned W = fp_width(fp_format_e'(f));
    localparam int unsigned E = exp_width(fp_format_e'(f));
    localparam int unsigned M = W - E - 1;

    if (W <= LANE_W) begin : gen_active
      logic [W-1:0] a, b, res;
      logic         a_nan, b_nan, a_snan, b_snan;
      logic         a_less, sgnj_sign;

      assign a = operand_a_i[W-1:0];
      assign b = operand_b_i[W-1:0];

      // Exponent all ones with a nonzero mantissa; quiet bit is the top mantissa bit
      assign a_nan  = (&a[W-2:M]) & (|a[M-1:0]);
      assign b_nan  = (&b[W-2:M]) & (|b[M-1:0]);
      assign a_snan = a_nan & ~a[M-1];
      assign b_snan = b_nan & ~b[M-1];

      // Differing signs order -0 below +0 as well
      always_comb begin : compare
        if (a[W-1] != b[W-1]) begin
          a_less = a[W-1];
        end else if (a[W-1]) begin
          a_less = a[W-2:0] > b[W-2:0];  // Both negative
        end else begin
          a_less = a[W-2:0] < b[W-2:0];
        end
      end

      always_comb begin : sign_select
        case (rnd_mode_i)
          RNE:     sgnj_sign = b[W-1];
          RTZ:     sgnj_sign = ~b[W-1];
          RDN:     sgnj_sign = a[W-1] ^ b[W-1];
          default: sgnj_sign = a[W-1];
        endcase
      end

      always_comb begin : operation
        if (op_i == SGNJ) begin
          res = {sgnj_sign, a[W-2:0]};
        end else if (a_nan & b_nan) begin
          res = {1'b0, {E{1'b1}}, 1'b1, {(M-1){1'b0}}};  // Canonical quiet NaN
        end else if (a_nan) begin
          res = b;
        end else if (b_nan) begin
          res = a;
        end else if (rnd_mode_i == RTZ) begin
          res = a_less ? b : a;  // Max
        end else begin
          res = a_less ? a : b;  // Min
        end
      end

      assign fmt_result[f]  = SLICE_WIDTH'(res);
      assign fmt_invalid[f] = (op_i == MINMAX) & (a_snan | b_snan);
    end else begin : gen_inactive
      // Format wider than this lane
      assign fmt_result[f]  = '1;
      assign fmt_invalid[f] = 1'b0;
    end
  end

  always_comb begin : fmt_select
    result_d = '1;
    status_d = '0;
    if (int'(dst_fmt_i) < NUM_FORMATS) begin
      result_d    = fmt_result[dst_fmt_i];
      status_d.nv = fmt_invalid[dst_fmt_i];
    end
  end

  // --------------------
  // Lane pipeline
  // --------------------
  // Index i holds the item after i register stages
  logic [PAYLOAD_W-1:0] pipe_data_q  [LANE_PIPE_STAGES+1];
  logic                 pipe_valid_q [LANE_PIPE_STAGES+1];
  logic                 pipe_ready   [LANE_PIPE_STAGES+1];

  assign pipe_data_q[0]  = {result_d, status_d, vector_i, dst_fmt_i, tag_i, mask_i};
  assign pipe_valid_q[0] = in_valid_i;

  for (genvar i = 0; i < LANE_PIPE_STAGES; i++) begin : gen_stage
    // Advance when the next stage takes the item or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
      if (!rst_n_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (pipe_ready[i] & pipe_valid_q[i]) begin
        pipe_data_q[i+1] <= pipe_data_q[i];
      end
    end
  end

  assign pipe_ready[LANE_PIPE_STAGES] = out_ready_i;  // Driven downstream
  assign in_ready_o                   = pipe_ready[0];
  assign out_valid_o                  = pipe_valid_q[LANE_PIPE_STAGES];

  assign {result_o, status_o, vector_o, dst_fmt_o, tag_o, mask_o} =
      pipe_data_q[LANE_PIPE_STAGES];

  always_comb begin : busy_flag
    busy_o = 1'b0;
    for (int i = 1; i <= LANE_PIPE_STAGES; i++) begin
      busy_o |= pipe_valid_q[i];
    end
  end

endmodule

`default_nettype wire

/* rtl/operand_unpack.sv */
// Splits both operand words into right-aligned per-lane fields for the selected format
`timescale 1ns/1ps
`default_nettype none

module operand_unpack (
  input  logic [simd_slice_pkg::SLICE_WIDTH-1:0]                              operand_a_i,
  input  logic [simd_slice_pkg::SLICE_WIDTH-1:0]                              operand_b_i,
  input  simd_slice_pkg::fp_format_e                                          dst_fmt_i,
  output logic [simd_slice_pkg::NUM_LANES-1:0][simd_slice_pkg::SLICE_WIDTH-1:0] lane_a_o,
  output logic [simd_slice_pkg::NUM_LANES-1:0][simd_slice_pkg::SLICE_WIDTH-1:0] lane_b_o
);

  import simd_slice_pkg::*;

  fp_word_u word_a;
  fp_word_u word_b;

  assign word_a = operand_a_i;
  assign word_b = operand_b_i;

  // Field of one lane, zero-extended; lanes with no field in this format get zero
  function automatic logic [SLICE_WIDTH-1:0] lane_field(fp_word_u word, fp_format_e fmt,
                                                        int unsigned lane);
    logic [SLICE_WIDTH-1:0] field;
    field = '0;
    case (fmt)
      FP32: begin
        if (lane == 0) field = word.fp32;
      end
      FP16: begin
        if (lane < 2) field[15:0] = word.fp16[lane[0]];
      end
      default: begin
        field[7:0] = word.fp8[lane[1:0]];
      end
    endcase
    return field;
  endfunction

  always_comb begin : slice_lanes
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      lane_a_o[lane] = lane_field(word_a, dst_fmt_i, lane);
      lane_b_o[lane] = lane_field(word_b, dst_fmt_i, lane);
    end
  end

endmodule

`default_nettype wire

/* rtl/result_pack.sv */
// Packs lane results for the destination format with NaN-boxing and merges masked status
`timescale 1ns/1ps
`default_nettype none

module result_pack (
  input  logic [simd_slice_pkg::SLICE_WIDTH-1:0] lane_result_i [simd_slice_pkg::NUM_LANES],
  input  simd_slice_pkg::status_t                lane_status_i [simd_slice_pkg::NUM_LANES],
  input  logic [simd_slice_pkg::NUM_LANES-1:0]   lane_mask_i,
  input  logic [simd_slice_pkg::NUM_LANES-1:0]   lane_valid_i,
  input  simd_slice_pkg::fp_format_e             dst_fmt_i,
  input  logic                                   vector_i,
  output logic [simd_slice_pkg::SLICE_WIDTH-1:0] result_o,
  output simd_slice_pkg::status_t                status_o
);

  import simd_slice_pkg::*;

  logic [NUM_LANES-1:0] lane_used;
  fp_word_u             packed_word;

  // A lane contributes only if it is valid, part of the operation and has a field
  always_comb begin : lane_select
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      lane_used[lane] = lane_valid_i[lane] & ((lane == 0) | vector_i) &
                        (lane < lanes_of(dst_fmt_i));
    end
  end

  // --------------------
  // Result assembly
  // --------------------
  always_comb begin : pack
    packed_word = '1;  // NaN-box everything not written below
    case (dst_fmt_i)
      FP32: begin
        if (lane_used[0]) packed_word.fp32 = lane_result_i[0];
      end
      FP16: begin
        for (int unsigned lane = 0; lane < 2; lane++) begin
          if (lane_used[lane]) packed_word.fp16[lane] = lane_result_i[lane][15:0];
        end
      end
      FP8: begin
        for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
          if (lane_used[lane]) packed_word.fp8[lane] = lane_result_i[lane][7:0];
        end
      end
      default: begin
        packed_word = '1;
      end
    endcase
  end

  assign result_o = packed_word;

  // Flags of masked-off lanes are dropped
  always_comb begin : status_collapse
    status_o = '0;
    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      if (lane_used[lane]) begin
        status_o |= lane_status_i[lane] & {NUM_STATUS{lane_mask_i[lane]}};
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/simd_noncomp_slice.sv */
// Top of the SIMD non-computational FP slice; wires unpack, four lanes and the result packer
`timescale 1ns/1ps
`default_nettype none

module simd_noncomp_slice (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic [simd_slice_pkg::SLICE_WIDTH-1:0] operand_a_i,
  input  logic [simd_slice_pkg::SLICE_WIDTH-1:0] operand_b_i,
  input  simd_slice_pkg::operation_e             op_i,
  input  simd_slice_pkg::roundmode_e             rnd_mode_i,
  input  simd_slice_pkg::fp_format_e             dst_fmt_i,
  input  logic                                   vectorial_op_i,
  input  logic [simd_slice_pkg::NUM_LANES-1:0]   simd_mask_i,
  input  logic [simd_slice_pkg::TAG_WIDTH-1:0]   tag_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  output logic [simd_slice_pkg::SLICE_WIDTH-1:0] result_o,
  output simd_slice_pkg::status_t                status_o,
  output logic [simd_slice_pkg::TAG_WIDTH-1:0]   tag_o,
  output logic                                   out_valid_o,
  input  logic                                   out_ready_i,
  output logic                                   busy_o
);

  import simd_slice_pkg::*;

  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_a;
  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_b;

  logic [SLICE_WIDTH-1:0] lane_result [NUM_LANES];
  status_t                lane_status [NUM_LANES];
  logic                   lane_vector [NUM_LANES];
  fp_format_e             lane_fmt    [NUM_LANES];
  logic [TAG_WIDTH-1:0]   lane_tag    [NUM_LANES];
  logic                   lane_in_ready [NUM_LANES];

  wire [NUM_LANES-1:0] lane_out_valid;
  wire [NUM_LANES-1:0] lane_mask;
  wire [NUM_LANES-1:0] lane_busy;

  logic result_is_vector;

  // --------------------
  // Input side
  // --------------------
  operand_unpack i_operand_unpack (
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .dst_fmt_i   ( dst_fmt_i   ),
    .lane_a_o    ( lane_a      ),
    .lane_b_o    ( lane_b      )
  );

  assign in_ready_o = lane_in_ready[0];  // Upstream ready comes from lane 0

  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    logic in_valid, out_ready;

    // Upper lanes take an item only when lane 0 takes it, so they stay in lockstep
    assign in_valid  = in_valid_i & ((lane == 0) | (vectorial_op_i & lane_in_ready[0]));
    assign out_ready = out_ready_i & ((lane == 0) | result_is_vector);

    noncomp_lane #(
      .LaneIdx ( lane )
    ) i_noncomp_lane (
      .clk_i       ( clk_i                ),
      .rst_n_i     ( rst_n_i              ),
      .operand_a_i ( lane_a[lane]         ),
      .operand_b_i ( lane_b[lane]         ),
      .op_i        ( op_i                 ),
      .rnd_mode_i  ( rnd_mode_i           ),
      .dst_fmt_i   ( dst_fmt_i            ),
      .vector_i    ( vectorial_op_i       ),
      .mask_i      ( simd_mask_i[lane]    ),
      .tag_i       ( tag_i                ),
      .in_valid_i  ( in_valid             ),
      .in_ready_o  ( lane_in_ready[lane]  ),
      .result_o    ( lane_result[lane]    ),
      .status_o    ( lane_status[lane]    ),
      .vector_o    ( lane_vector[lane]    ),
      .dst_fmt_o   ( lane_fmt[lane]       ),
      .tag_o       ( lane_tag[lane]       ),
      .mask_o      ( lane_mask[lane]      ),
      .out_valid_o ( lane_out_valid[lane] ),
      .out_ready_i ( out_ready            ),
      .busy_o      ( lane_busy[lane]      )
    );
  end

  // --------------------
  // Output side
  // --------------------
  assign result_is_vector = lane_vector[0];  // Aux of lane 0 describes the result

  result_pack i_result_pack (
    .lane_result_i ( lane_result      ),
    .lane_status_i ( lane_status      ),
    .lane_mask_i   ( lane_mask        ),
    .lane_valid_i  ( lane_out_valid   ),
    .dst_fmt_i     ( lane_fmt[0]      ),
    .vector_i      ( result_is_vector ),
    .result_o      ( result_o         ),
    .status_o      ( status_o         )
  );

  assign out_valid_o = lane_out_valid[0];
  assign tag_o       = lane_tag[0];
  assign busy_o      = |lane_busy;

endmodule

`default_nettype wire

/* rtl/simd_slice_pkg.sv */
// Formats, operation codes, widths and helpers shared by every block of the SIMD FP slice
`default_nettype none

package simd_slice_pkg;

  // --------------------
  // Slice geometry
  // --------------------
  localparam int unsigned SLICE_WIDTH      = 32;
  localparam int unsigned NUM_LANES        = 4;
  localparam int unsigned NUM_FORMATS      = 3;
  localparam int unsigned LANE_PIPE_STAGES = 2;
  localparam int unsigned TAG_WIDTH        = 4;
  localparam int unsigned NUM_STATUS       = 5;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2  // E5M2
  } fp_format_e;

  typedef enum logic {
    SGNJ   = 1'b0,
    MINMAX = 1'b1
  } operation_e;

  // Variant select, named after the rounding modes that carry it
  typedef enum logic [2:0] {
    RNE = 3'b000,  // SGNJ copy sign / MINMAX min
    RTZ = 3'b001,  // SGNJ negated sign / MINMAX max
    RDN = 3'b010   // SGNJ xor of signs
  } roundmode_e;

  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // One datapath word seen in each format
  typedef union packed {
    logic [SLICE_WIDTH-1:0] fp32;
    logic [1:0][15:0]       fp16;
    logic [3:0][7:0]        fp8;
  } fp_word_u;

  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP32:    return 32;
      FP16:    return 16;
      default: return 8;
    endcase
  endfunction

  function automatic int unsigned exp_width(fp_format_e fmt);
    case (fmt)
      FP32:    return 8;
      default: return 5;  // FP16 and E5M2 share the exponent width
    endcase
  endfunction

  function automatic int unsigned lanes_of(fp_format_e fmt);
    return SLICE_WIDTH / fp_width(fmt);
  endfunction

  // Widest format a lane has to serve
  function automatic int unsigned lane_width(int unsigned lane);
    if (lane == 0) return 32;
    if (lane == 1) return 16;
    return 8;
  endfunction

endpackage

`default_nettype wire

/* testbench/slice_assert.sv */
// Concurrent checks on the slice output handshake and reset state, bound into the slice top
`timescale 1ns/1ps
`default_nettype none

module slice_assert (
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input logic                                   out_valid_i,
  input logic                                   out_ready_i,
  input logic [simd_slice_pkg::SLICE_WIDTH-1:0] result_i,
  input logic                                   busy_i
);

  // A stalled result holds until taken
  hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i))
    else $error("output valid or result changed while out_ready was low");

  busy_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_i |-> busy_i)
    else $error("out_valid high while busy low");

  idle_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !out_valid_i)
    else $error("out_valid high right after reset release");

endmodule

bind simd_noncomp_slice slice_assert slice_assert_i (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .out_valid_i ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .result_i    ( result_o    ),
  .busy_i      ( busy_o      )
);

`default_nettype wire

/* testbench/tb_simd_noncomp_slice.sv */
// Self-checking testbench for the SIMD non-computational slice; compile with the RTL and run as top
`timescale 1ns/1ps
`default_nettype none

module tb_simd_noncomp_slice;

  import simd_slice_pkg::*;

  localparam int unsigned NUM_DIRECTED = 16;
  localparam int unsigned NUM_RANDOM   = 300;
  localparam int unsigned NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
  localparam int unsigned CYCLE_LIMIT  = NUM_OPS * 4 + 100;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  operation_e  op_i;
  roundmode_e  rnd_mode_i;
  fp_format_e  dst_fmt_i;
  logic        vectorial_op_i;
  logic [3:0]  simd_mask_i;
  logic [3:0]  tag_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] result_o;
  status_t     status_o;
  logic [3:0]  tag_o;
  logic        out_valid_o;
  logic        out_ready_i;
  logic        busy_o;

  logic [31:0] lfsr_q;
  int unsigned cycle_cnt;
  int unsigned mismatch_cnt;
  int unsigned failure_cnt;
  logic        bp_enable;    // Random out_ready when set
  logic        ready_held;   // out_ready_i stays high, so latency must be exactly 2
  logic [40:0] exp_q [$];    // {tag, status, result}
  int unsigned acc_q [$];    // Cycle of acceptance

  simd_noncomp_slice dut0 (.*);

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);  // Galois form
  endfunction

  task automatic draw(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Kind 0 quiet NaN, 1 signaling NaN, else zero
  function automatic logic [31:0] special_field(int unsigned w, int unsigned e,
                                                logic [1:0] kind, logic sign);
    logic [31:0] exp_ones;
    logic [31:0] f;
    exp_ones = ((32'd1 << e) - 1) << (w - e - 1);
    case (kind)
      2'd0:    f = exp_ones | (32'd1 << (w - e - 2));
      2'd1:    f = exp_ones | 32'd1;
      default: f = '0;
    endcase
    return f | (32'(sign) << (w - 1));
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [32:0] expect_field(logic [31:0] a, logic [31:0] b, int unsigned w,
                                               int unsigned e, operation_e op, roundmode_e rnd);
    int unsigned m;
    logic [31:0] half, mag_a, mag_b, key_a, key_b, exp_ones, res;
    logic        sign, nan_a, nan_b, snan_a, snan_b;
    m        = w - e - 1;
    half     = 32'd1 << (w - 1);
    mag_a    = a & (half - 1);
    mag_b    = b & (half - 1);
    exp_ones = ((32'd1 << e) - 1) << m;
    nan_a    = ((mag_a & exp_ones) == exp_ones) && ((mag_a & ~exp_ones) != 0);
    nan_b    = ((mag_b & exp_ones) == exp_ones) && ((mag_b & ~exp_ones) != 0);
    snan_a   = nan_a && !mag_a[m-1];
    snan_b   = nan_b && !mag_b[m-1];
    key_a    = a[w-1] ? (half - 1 - mag_a) : (half + mag_a);  // Monotonic ordering key
    key_b    = b[w-1] ? (half - 1 - mag_b) : (half + mag_b);
    if (op == SGNJ) begin
      case (rnd)
        RNE:     sign = b[w-1];
        RTZ:     sign = ~b[w-1];
        default: sign = a[w-1] ^ b[w-1];
      endcase
      return {1'b0, mag_a | (32'(sign) << (w - 1))};
    end
    if (nan_a && nan_b) res = exp_ones | (32'd1 << (m - 1));
    else if (nan_a)     res = b;
    else if (nan_b)     res = a;
    else if (rnd == RTZ) res = (key_a > key_b) ? a : b;
    else                res = (key_a < key_b) ? a : b;
    return {snan_a | snan_b, res};
  endfunction

  function automatic logic [36:0] ref_slice(logic [31:0] a, logic [31:0] b, operation_e op,
                                            roundmode_e rnd, fp_format_e fmt, logic vec,
                                            logic [3:0] mask);
    int unsigned w, e, used;
    logic [31:0] fmask, res;
    logic [32:0] r;
    logic        nv;
    w     = (fmt == FP32) ? 32 : (fmt == FP16) ? 16 : 8;
    e     = (fmt == FP32) ? 8 : 5;
    used  = vec ? 32 / w : 1;
    fmask = 32'hFFFF_FFFF >> (32 - w);
    res   = 32'hFFFF_FFFF;  // NaN-box
    nv    = 1'b0;
    for (int unsigned i = 0; i < used; i++) begin
      r   = expect_field((a >> (i * w)) & fmask, (b >> (i * w)) & fmask, w, e, op, rnd);
      res = (res & ~(fmask << (i * w))) | (r[31:0] << (i * w));
      nv  = nv | (r[32] & mask[i]);
    end
    return {nv, 4'b0000, res};
  endfunction

  // Presents one item and returns 2 ns after the edge that accepts it
  task automatic send(logic [31:0] a, logic [31:0] b, operation_e op, roundmode_e rnd,
                      fp_format_e fmt, logic vec, logic [3:0] mask, logic [3:0] tag);
    operand_a_i    = a;
    operand_b_i    = b;
    op_i           = op;
    rnd_mode_i     = rnd;
    dst_fmt_i      = fmt;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    tag_i          = tag;
    in_valid_i     = 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #2;
  endtask

  task automatic inject_specials(inout logic [31:0] word, input int unsigned w,
                                 input int unsigned e);
    logic [31:0] r, fmask;
    fmask = 32'hFFFF_FFFF >> (32 - w);
    for (int unsigned i = 0; i < 32 / w; i++) begin
      draw(3, r);
      if (r < 3) begin  // 3 in 8 fields become NaN or zero
        word = (word & ~(fmask << (i * w))) |
               (special_field(w, e, r[1:0], word[i*w]) << (i * w));
      end
    end
  endtask

  task automatic send_random();
    logic [31:0] r, a, b, mask, tag, vec;
    fp_format_e  fmt;
    operation_e  op;
    roundmode_e  rnd;
    draw(2, r);
    fmt = (r[1:0] == 2'd0) ? FP32 : (r[1:0] == 2'd1) ? FP16 : FP8;
    draw(1, r);
    op = operation_e'(r[0]);
    draw(2, r);
    rnd = (op == SGNJ && r[1]) ? RDN : (r[0] ? RTZ : RNE);
    draw(32, a);
    draw(32, b);
    inject_specials(a, 32 / lanes_of(fmt), (fmt == FP32) ? 8 : 5);
    inject_specials(b, 32 / lanes_of(fmt), (fmt == FP32) ? 8 : 5);
    draw(1, vec);
    draw(4, mask);
    draw(4, tag);
    draw(2, r);
    if (r[1:0] == 2'd0) begin  // Occasional idle cycle
      in_valid_i = 1'b0;
      @(posedge clk_i);
      #2;
    end
    send(a, b, op, rnd, fmt, vec[0], mask[3:0], tag[3:0]);
  endtask

  task automatic wait_drain();
    in_valid_i = 1'b0;
    while (exp_q.size() != 0 || busy_o) @(negedge clk_i);
    @(posedge clk_i);  // Back to the drive point after the rising edge
    #2;
  endtask

  // --------------------
  // Clock, watchdog, back-pressure
  // --------------------
  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d items still pending", cycle_cnt, exp_q.size());
    $display("test failed");
    $finish;
  end

  initial begin : back_pressure
    logic [31:0] r;
    forever begin
      @(posedge clk_i);
      r = '1;
      if (bp_enable) draw(2, r);
      #2;
      out_ready_i = (r[1:0] != 2'd0);
    end
  end

  // Scoreboard sampled at the falling edge where handshakes are stable
  initial begin : compare
    logic [40:0] exp_item;
    int unsigned acc;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          failure_cnt++;
          $display("%0t: output handshake with no item pending", $time);
        end else begin
          exp_item = exp_q.pop_front();
          acc      = acc_q.pop_front();
          if (result_o !== exp_item[31:0]) begin
            mismatch_cnt++;
            $display("mismatch at %0t: result_o got %h expected %h", $time, result_o,
                     exp_item[31:0]);
          end
          if (status_o !== exp_item[36:32]) begin
            mismatch_cnt++;
            $display("mismatch at %0t: status_o got %b expected %b", $time, status_o,
                     exp_item[36:32]);
          end
          if (tag_o !== exp_item[40:37]) begin
            mismatch_cnt++;
            $display("mismatch at %0t: tag_o got %h expected %h", $time, tag_o, exp_item[40:37]);
          end
          if ((ready_held && cycle_cnt - acc != 2) || cycle_cnt - acc < 2) begin
            failure_cnt++;
            $display("%0t: result came %0d cycles after acceptance", $time, cycle_cnt - acc);
          end
        end
      end
      if (rst_n_i && in_valid_i && in_ready_o) begin
        exp_q.push_back({tag_i, ref_slice(operand_a_i, operand_b_i, op_i, rnd_mode_i,
                                          dst_fmt_i, vectorial_op_i, simd_mask_i)});
        acc_q.push_back(cycle_cnt);
      end
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main
    logic [31:0] sgnj_a [3];
    logic [31:0] sgnj_b [3];
    sgnj_a = '{32'h3F80_0000, 32'hFFFF_BC00, 32'hFFFF_FF3C};
    sgnj_b = '{32'hC000_0000, 32'hFFFF_4000, 32'hFFFF_FFC0};
    lfsr_q         = 32'd73039;
    mismatch_cnt   = 0;
    failure_cnt    = 0;
    bp_enable      = 1'b0;
    ready_held     = 1'b1;
    rst_n_i        = 1'b0;
    out_ready_i    = 1'b1;
    in_valid_i     = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = SGNJ;
    rnd_mode_i     = RNE;
    dst_fmt_i      = FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = '0;
    tag_i          = '0;
    repeat (5) @(posedge clk_i);
    #2 rst_n_i = 1'b1;
    @(negedge clk_i);
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      failure_cnt++;
      $display("%0t: slice not idle and ready after reset", $time);
    end
    @(posedge clk_i);
    #2;
    // Scalar sign injection, every format and variant, back to back
    for (int f = 0; f < 3; f++) begin
      send(sgnj_a[f], sgnj_b[f], SGNJ, RNE, fp_format_e'(f), 1'b0, 4'hF, 4'(f * 3));
      send(sgnj_a[f], sgnj_b[f], SGNJ, RTZ, fp_format_e'(f), 1'b0, 4'hF, 4'(f * 3 + 1));
      send(sgnj_a[f], sgnj_b[f], SGNJ, RDN, fp_format_e'(f), 1'b0, 4'hF, 4'(f * 3 + 2));
    end
    // Min/max special cases
    send(32'h7FC0_0000, 32'h4040_0000, MINMAX, RNE, FP32, 1'b0, 4'h1, 4'h9);
    send(32'h7E00_7C01, 32'hFE00_7D00, MINMAX, RNE, FP16, 1'b1, 4'h1, 4'hA);
    send(32'h8000_8000, 32'h0080_0080, MINMAX, RNE, FP8, 1'b1, 4'hF, 4'hB);
    send(32'h8000_8000, 32'h0080_0080, MINMAX, RTZ, FP8, 1'b1, 4'hF, 4'hC);
    send(32'h007D_0000, 32'h3C3C_3C3C, MINMAX, RNE, FP8, 1'b1, 4'b0100, 4'hD);
    send(32'h007D_0000, 32'h3C3C_3C3C, MINMAX, RNE, FP8, 1'b1, 4'b1011, 4'hE);
    send(32'hFFFF_7C01, 32'hFFFF_3C00, MINMAX, RTZ, FP16, 1'b0, 4'h1, 4'hF);
    wait_drain();
    ready_held = 1'b0;
    bp_enable  = 1'b1;
    for (int unsigned i = 0; i < NUM_RANDOM; i++) begin
      send_random();
    end
    bp_enable = 1'b0;
    wait_drain();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
    if (mismatch_cnt == 0 && failure_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
